// ==== Bender.yml ====
package:
  name: aesRounds

sources:
  - files:
      - hdl/aesPkg.sv
      - hdl/roundIf.sv
      - hdl/subBytes.sv
      - hdl/mixColumns.sv
      - hdl/roundDatapath.sv
      - hdl/cipherControl.sv
      - hdl/aesRounds.sv
  - target: test
    files:
      - testbench/aesRounds_properties.sv
      - testbench/aesRoundsTb.sv

// ==== aesRounds.f ====
hdl/aesPkg.sv
hdl/roundIf.sv
hdl/subBytes.sv
hdl/mixColumns.sv
hdl/roundDatapath.sv
hdl/cipherControl.sv
hdl/aesRounds.sv
testbench/aesRounds_properties.sv
testbench/aesRoundsTb.sv

// ==== hdl/aesPkg.sv ====
// shared widths, types and the substitution table for the iterative cipher core
// every round adds the unexpanded cipher key, so results differ from standard AES
package aesPkg;

    localparam int BlockWidth = 128;
    localparam int ByteWidth  = 8;
    localparam int NumRounds  = 10;

    typedef logic [BlockWidth-1:0] block_t;
    typedef logic [ByteWidth-1:0]  byte_t;
    typedef logic [3:0]            roundIdx_t;

    // reduction constant for doubling in GF(2^8)
    localparam byte_t RoundPoly = 8'h1b;

    typedef enum logic {
        Idle,
        Running
    } cipherState_e;

    // forward substitution, indexed by the input byte
    localparam byte_t SboxTable [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

endpackage

// ==== hdl/aesRounds.sv ====
// top of the iterative cipher core
// pulse start with dataIn and key, the result comes with done ten cycles later
`timescale 1ns/1ps

module aesRounds (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  aesPkg::block_t dataIn,
    input  aesPkg::block_t key,
    output logic           done,
    output aesPkg::block_t dataOut
);

    roundIf rndIf ();

    cipherControl cipherControl_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .dataIn  (dataIn),
        .key     (key),
        .done    (done),
        .dataOut (dataOut),
        .rnd     (rndIf.control)
    );

    roundDatapath roundDatapath_inst (
        .rnd (rndIf.round)
    );

endmodule

// ==== hdl/cipherControl.sv ====
// holds the cipher state and key, steps ten rounds and strobes the result
// a start at any time reloads the block and restarts the count
`timescale 1ns/1ps

module cipherControl (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  aesPkg::block_t dataIn,
    input  aesPkg::block_t key,
    output logic           done,
    output aesPkg::block_t dataOut,
    roundIf.control        rnd
);
    import aesPkg::*;

    block_t       stateReg;
    block_t       keyReg;
    roundIdx_t    roundCnt;
    cipherState_e curState;

    always_ff @(posedge clk) begin
        if (rst) begin
            curState <= Idle;
            roundCnt <= '0;
        end else if (start) begin
            curState <= Running;
            roundCnt <= '0;
        end else if (curState == Running) begin
            if (rnd.finalRound) begin
                curState <= Idle;
                roundCnt <= '0;
            end else begin
                roundCnt <= roundCnt + roundIdx_t'(1);
            end
        end
    end

    // initial key add happens on capture
    always_ff @(posedge clk) begin
        if (start) begin
            stateReg <= dataIn ^ key;
            keyReg   <= key;
        end else if (curState == Running) begin
            stateReg <= rnd.roundResult;
        end
    end

    assign rnd.roundState = stateReg;
    // same key every round, no schedule
    assign rnd.roundKey   = keyReg;
    assign rnd.finalRound = (curState == Running) && (roundCnt == roundIdx_t'(NumRounds - 1));

    // result is only valid during the strobe cycle
    assign done    = rnd.finalRound;
    assign dataOut = done ? rnd.roundResult : '0;

endmodule

// ==== hdl/mixColumns.sv ====
// column mixing over GF(2^8), built from doubling and XOR only
// state is row major with row 0 in the top 32 bits
`timescale 1ns/1ps

module mixColumns (
    input  aesPkg::block_t stateIn,
    output aesPkg::block_t stateOut
);
    import aesPkg::*;

    byte_t cellIn  [4][4];
    byte_t cellDbl [4][4];
    byte_t cellOut [4][4];

    genvar r, c;
    generate
        for (r = 0; r < 4; r++) begin : genRow
            for (c = 0; c < 4; c++) begin : genCol
                assign cellIn[r][c] = stateIn[BlockWidth - ByteWidth*(4*r + c + 1) +: ByteWidth];
                // shift left, fold the carried bit back with the polynomial
                assign cellDbl[r][c] = {cellIn[r][c][ByteWidth-2:0], 1'b0}
                                     ^ (cellIn[r][c][ByteWidth-1] ? RoundPoly : '0);
                assign stateOut[BlockWidth - ByteWidth*(4*r + c + 1) +: ByteWidth] = cellOut[r][c];
            end
        end

        for (c = 0; c < 4; c++) begin : genMix
            // 3x is the doubled byte XOR the byte itself
            assign cellOut[0][c] = cellDbl[0][c] ^ cellIn[1][c] ^ cellIn[2][c]
                                 ^ cellDbl[3][c] ^ cellIn[3][c];
            assign cellOut[1][c] = cellDbl[0][c] ^ cellIn[0][c] ^ cellDbl[1][c]
                                 ^ cellIn[2][c] ^ cellIn[3][c];
            assign cellOut[2][c] = cellIn[0][c] ^ cellDbl[1][c] ^ cellIn[1][c]
                                 ^ cellDbl[2][c] ^ cellIn[3][c];
            assign cellOut[3][c] = cellIn[0][c] ^ cellIn[1][c] ^ cellDbl[2][c]
                                 ^ cellIn[2][c] ^ cellDbl[3][c];
        end
    endgenerate

endmodule

// ==== hdl/roundDatapath.sv ====
// one full cipher round with no registers
// substitution, row shift, optional column mix, then key add
`timescale 1ns/1ps

module roundDatapath (
    roundIf.round rnd
);
    import aesPkg::*;

    block_t subbed;
    block_t shifted;
    block_t mixed;

    subBytes subBytes_inst (
        .stateIn  (rnd.roundState),
        .stateOut (subbed)
    );

    // row r rotates left by r bytes, pure rewiring
    genvar r, c;
    generate
        for (r = 0; r < 4; r++) begin : genShiftRow
            for (c = 0; c < 4; c++) begin : genShiftCol
                assign shifted[BlockWidth - ByteWidth*(4*r + c + 1) +: ByteWidth] =
                    subbed[BlockWidth - ByteWidth*(4*r + ((c + r) % 4) + 1) +: ByteWidth];
            end
        end
    endgenerate

    mixColumns mixColumns_inst (
        .stateIn  (shifted),
        .stateOut (mixed)
    );

    // last round bypasses the column mix
    assign rnd.roundResult = (rnd.finalRound ? shifted : mixed) ^ rnd.roundKey;

endmodule

// ==== hdl/roundIf.sv ====
// links the round controller to the combinational round datapath
// controller supplies state, key and final flag, datapath returns the result
`timescale 1ns/1ps

interface roundIf;
    import aesPkg::*;

    block_t roundState;
    block_t roundKey;
    logic   finalRound;
    block_t roundResult;

    modport control (
        output roundState,
        output roundKey,
        output finalRound,
        input  roundResult
    );

    modport round (
        input  roundState,
        input  roundKey,
        input  finalRound,
        output roundResult
    );

endinterface

// ==== hdl/subBytes.sv ====
// byte substitution over the whole state
// sixteen independent lookups into the shared table
`timescale 1ns/1ps

module subBytes (
    input  aesPkg::block_t stateIn,
    output aesPkg::block_t stateOut
);
    import aesPkg::*;

    localparam int NumBytes = BlockWidth / ByteWidth;

    genvar i;
    generate
        for (i = 0; i < NumBytes; i++) begin : genLookup
            assign stateOut[i*ByteWidth +: ByteWidth] = SboxTable[stateIn[i*ByteWidth +: ByteWidth]];
        end
    endgenerate

endmodule

// ==== testbench/aesRoundsTb.sv ====
// testbench for the iterative cipher core
// runs fixed, random and restart blocks and compares against a behavioral model
`timescale 1ns/1ps

module aesRoundsTb;
    import aesPkg::*;

    localparam int          ClkPeriod   = 100;
    localparam int          DoneLatency = 10;
    localparam int          DoneTimeout = 40;
    localparam int          NumRandom   = 20;
    localparam int unsigned Seed        = 32'hd11b_bba5;

    logic   clk;
    logic   rst;
    logic   start;
    block_t dataIn;
    block_t key;
    logic   done;
    block_t dataOut;

    int passCount = 0;
    int failCount = 0;
    bit testOk;

    aesRounds aesRounds_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .dataIn  (dataIn),
        .key     (key),
        .done    (done),
        .dataOut (dataOut)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic byte_t gfDouble(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? RoundPoly : 8'h00);
    endfunction

    function automatic byte_t gfTriple(input byte_t b);
        return gfDouble(b) ^ b;
    endfunction

    // behavioral model of key add then ten rounds with the same key in each round
    function automatic block_t encryptBlock(input block_t blk, input block_t k);
        byte_t  s  [4][4];
        byte_t  t  [4][4];
        byte_t  kb [4][4];
        block_t res;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                kb[r][c] = k[BlockWidth - 1 - 8 * (4 * r + c) -: 8];
                s[r][c]  = blk[BlockWidth - 1 - 8 * (4 * r + c) -: 8] ^ kb[r][c];
            end
        end
        for (int rd = 0; rd < NumRounds; rd++) begin
            // substitute and rotate row r left by r in one pass
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    t[r][c] = SboxTable[s[r][(c + r) % 4]];
                end
            end
            for (int c = 0; c < 4; c++) begin
                if (rd < NumRounds - 1) begin
                    s[0][c] = gfDouble(t[0][c]) ^ t[1][c] ^ t[2][c] ^ gfTriple(t[3][c]);
                    s[1][c] = gfTriple(t[0][c]) ^ gfDouble(t[1][c]) ^ t[2][c] ^ t[3][c];
                    s[2][c] = t[0][c] ^ gfTriple(t[1][c]) ^ gfDouble(t[2][c]) ^ t[3][c];
                    s[3][c] = t[0][c] ^ t[1][c] ^ gfTriple(t[2][c]) ^ gfDouble(t[3][c]);
                end else begin
                    for (int r = 0; r < 4; r++) begin
                        s[r][c] = t[r][c];
                    end
                end
            end
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    s[r][c] = s[r][c] ^ kb[r][c];
                end
            end
        end
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                res[BlockWidth - 1 - 8 * (4 * r + c) -: 8] = s[r][c];
            end
        end
        return res;
    endfunction

    function automatic block_t randomBlock();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // start is held for one cycle, returns at the next falling edge
    task automatic driveStart(input block_t blk, input block_t k);
        dataIn = blk;
        key    = k;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;
    endtask

    // counts falling edges since start was driven, bounded by the timeout
    task automatic waitForDone(output int cycles, output bit seen);
        cycles = 1;
        while (done !== 1'b1 && cycles < DoneTimeout) begin
            @(negedge clk);
            cycles++;
        end
        seen = (done === 1'b1);
    endtask

    task automatic checkResult(input string name, input block_t expected);
        int cycles;
        bit seen;
        waitForDone(cycles, seen);
        if (!seen) begin
            $display("%s: timed out waiting for done", name);
            testOk = 1'b0;
        end else begin
            if (cycles != DoneLatency) begin
                $display("MISMATCH %s latency expected %0d actual %0d",
                         name, DoneLatency, cycles);
                testOk = 1'b0;
            end
            if (dataOut !== expected) begin
                $display("MISMATCH %s expected %h actual %h", name, expected, dataOut);
                testOk = 1'b0;
            end
            @(negedge clk);
            if (done !== 1'b0) begin
                $display("%s: done stayed high for more than one cycle", name);
                testOk = 1'b0;
            end
        end
    endtask

    task automatic finishTest(input string name);
        if (testOk) begin
            passCount++;
            $display("test %s passed", name);
        end else begin
            failCount++;
            $display("test %s failed", name);
        end
    endtask

    task automatic runVector(input string name, input block_t blk, input block_t k);
        testOk = 1'b1;
        driveStart(blk, k);
        checkResult(name, encryptBlock(blk, k));
        finishTest(name);
    endtask

    task automatic checkIdle(input string name, input int numCycles);
        testOk = 1'b1;
        for (int i = 0; i < numCycles; i++) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                $display("MISMATCH %s expected %b actual %b", name, 1'b0, done);
                testOk = 1'b0;
            end
            if (dataOut !== '0) begin
                $display("MISMATCH %s expected %h actual %h", name, block_t'(0), dataOut);
                testOk = 1'b0;
            end
        end
        finishTest(name);
    endtask

    // second start five cycles in, only the second block may come out
    task automatic checkRestart(input string name);
        block_t blkA;
        block_t keyA;
        block_t blkB;
        block_t keyB;
        blkA   = randomBlock();
        keyA   = randomBlock();
        blkB   = randomBlock();
        keyB   = randomBlock();
        testOk = 1'b1;
        driveStart(blkA, keyA);
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                $display("%s: done rose before the restart", name);
                testOk = 1'b0;
            end
        end
        driveStart(blkB, keyB);
        checkResult(name, encryptBlock(blkB, keyB));
        for (int i = 0; i < 2 * DoneLatency; i++) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                $display("%s: a second done followed the restart", name);
                testOk = 1'b0;
            end
        end
        finishTest(name);
    endtask

    initial begin
        int propFails;
        void'($urandom(Seed));
        rst      = 1'b1;
        start    = 1'b0;
        dataIn   = '0;
        key      = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        checkIdle("afterReset", 8);
        runVector("zeroVector", '0, '0);
        runVector("knownVector", 128'h00112233_44556677_8899aabb_ccddeeff,
                  128'h00010203_04050607_08090a0b_0c0d0e0f);
        for (int i = 0; i < NumRandom; i++) begin
            runVector($sformatf("random%0d", i), randomBlock(), randomBlock());
        end
        checkRestart("restart");

        propFails = aesRounds_inst.cipherControl_inst.aesRoundsProperties_inst.assertFails;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passCount, failCount, propFails);
        if (failCount == 0 && propFails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== testbench/aesRounds_properties.sv ====
// control checks on the round controller, bound into every cipherControl
// watches the done strobe, its latency after start and the output gating
`timescale 1ns/1ps

module aesRoundsProperties (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input logic                 done,
    input aesPkg::block_t       dataOut,
    input aesPkg::cipherState_e curState
);
    import aesPkg::*;

    int assertFails = 0;

    // strobe lasts a single cycle
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done was high for two consecutive cycles");
            assertFails++;
        end

    // an idle controller without a start stays quiet
    assert property (@(posedge clk) disable iff (rst)
        ((curState == Idle) && !start) |=> !done)
        else begin
            $error("done was high after the controller was idle without a start");
            assertFails++;
        end

    // start captured at one edge, done seen ten edges later unless restarted
    assert property (@(posedge clk) disable iff (rst)
        (start ##1 (!start) [*NumRounds]) |-> done)
        else begin
            $error("done did not follow start after the expected number of cycles");
            assertFails++;
        end

    assert property (@(posedge clk) disable iff (rst) !done |-> (dataOut == '0))
        else begin
            $error("dataOut was nonzero while done was low");
            assertFails++;
        end

endmodule

bind cipherControl aesRoundsProperties aesRoundsProperties_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .done     (done),
    .dataOut  (dataOut),
    .curState (curState)
);
